//--- isa_pkg.sv
/*
	Instruction set of the scalar pipeline.
	One 32-bit format: opcode nibble, three register nibbles, 16-bit immediate.
	Opcodes 12 to 14 are unassigned and execute as NOP.
*/
`default_nettype none

package isa_pkg;

	localparam int INSTR_W = 32;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SHL  = 4'd6,
		OP_SHR  = 4'd7,
		OP_ADDI = 4'd8,
		OP_LUI  = 4'd9,
		OP_BEQ  = 4'd10,
		OP_JMP  = 4'd11,
		OP_HALT = 4'd15
	} opcode_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [3:0]  dst;
		logic [3:0]  src1;
		logic [3:0]  src2;
		logic [15:0] imm;
	} instr_t;

	// Register result producers
	function automatic logic op_writes_reg(opcode_t op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
			OP_ADDI, OP_LUI};
	endfunction

	function automatic logic op_reads_src1(opcode_t op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
			OP_ADDI, OP_BEQ};
	endfunction

	// ADDI and LUI take the immediate instead of src2
	function automatic logic op_reads_src2(opcode_t op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
			OP_BEQ};
	endfunction

endpackage

`default_nettype wire

//--- core_pkg.sv
/*
	Widths and stage payloads of the scalar pipeline.
	The pc field is 16 bits wide, so the instruction memory holds at most 64K words.
*/
`default_nettype none

package core_pkg;

	import isa_pkg::*;

	localparam int DATA_W   = 32;
	localparam int NUM_REGS = 16;

	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [DATA_W-1:0]           data_t;
	typedef logic [15:0]                 pc_t;

	// Issue to register read
	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    dst;
		reg_idx_t    src1;
		reg_idx_t    src2;
		logic [15:0] imm;
		pc_t         pc;
		logic        wr;
	} read_op_t;

	// Register read to execute
	typedef struct packed {
		read_op_t op;
		data_t    src1_data;
		data_t    src2_data;
	} exec_op_t;

endpackage

`default_nettype wire

//--- instr_mem.sv
/*
	Instruction memory, one synchronous read port and a four-phase store port.
	A word is written once per handshake, on the edge that raises store_ack.
	The read register only loads when fetch_valid is high.
	The host must not store while the core is busy.
*/
`timescale 1ns/1ps
`default_nettype none

module instr_mem
	import isa_pkg::*;
#(
	parameter int IMEM_DEPTH = 64,
	localparam int AW = $clog2(IMEM_DEPTH)
) (
	input  wire            clock,
	input  wire            reset,
	input  wire            store_req,
	input  wire  [AW-1:0]  store_addr,
	input  wire  instr_t   store_instr,
	output logic           store_ack,
	input  wire            fetch_valid,
	input  wire  [AW-1:0]  fetch_addr,
	output instr_t         fetch_instr,
	input  wire            busy
);

	logic [INSTR_W-1:0] mem [IMEM_DEPTH];
	logic               store_wr;

	// Rising request phase only
	assign store_wr = store_req & ~store_ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			store_ack <= 1'b0;
		end else if (store_wr) begin
			store_ack <= 1'b1;
		end else if (!store_req && store_ack) begin
			store_ack <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (store_wr) begin
			mem[store_addr] <= store_instr;
		end
		if (fetch_valid) begin
			fetch_instr <= instr_t'(mem[fetch_addr]);
		end
	end

	//////////////////////////////
	// Handshake checks

	a_no_store_busy: assert property (@(posedge clock) disable iff (reset)
		$rose(store_req) |-> !busy);

	// Request is released only after it was acknowledged
	a_req_held_for_ack: assert property (@(posedge clock) disable iff (reset)
		$fell(store_req) |-> $past(store_ack));

endmodule

`default_nettype wire

//--- fetch_unit.sv
/*
	Program counter and fetch slot.
	The word requested with fetch_valid returns one cycle later from instr_mem.
	The instr_mem read register keeps that word stable while issue stalls.
	start restarts at address 0, halt stops fetching, redirect drops the
	word in flight. The PC wraps at IMEM_DEPTH.
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
	import isa_pkg::*;
	import core_pkg::*;
#(
	parameter int IMEM_DEPTH = 64,
	localparam int AW = $clog2(IMEM_DEPTH)
) (
	input  wire            clock,
	input  wire            reset,
	input  wire            start,
	input  wire            stall,
	input  wire            redirect,
	input  wire  pc_t      redirect_pc,
	input  wire            halt,
	input  wire  instr_t   fetch_instr,
	output logic           fetch_valid,
	output logic [AW-1:0]  fetch_addr,
	output instr_t         fetched_instr,
	output pc_t            fetched_pc,
	output logic           fetched_valid
);

	logic          running;
	logic [AW-1:0] pc;

	// No request while issue is blocked or the stream changes
	assign fetch_valid   = running & ~stall & ~redirect & ~halt;
	assign fetch_addr    = pc;
	assign fetched_instr = fetch_instr;

	always_ff @(posedge clock) begin
		if (reset) begin
			running       <= 1'b0;
			pc            <= '0;
			fetched_valid <= 1'b0;
		end else if (start) begin
			running       <= 1'b1;
			pc            <= '0;
			fetched_valid <= 1'b0;
		end else if (halt) begin
			running       <= 1'b0;
			fetched_valid <= 1'b0;
		end else if (redirect) begin
			pc            <= redirect_pc[AW-1:0];
			fetched_valid <= 1'b0;
		end else if (!stall) begin
			fetched_valid <= fetch_valid;
			if (fetch_valid) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// PC of the word that arrives next cycle
	always_ff @(posedge clock) begin
		if (!stall) begin
			fetched_pc <= pc_t'(pc);
		end
	end

endmodule

`default_nettype wire

//--- hazard_issue.sv
/*
	Decode, scoreboard and issue.
	A register bit is set when a writer issues and cleared on its write-back.
	An instruction waits while any register it reads or writes is pending.
	flush empties the scoreboard, since every younger writer is killed.
*/
`timescale 1ns/1ps
`default_nettype none

module hazard_issue
	import isa_pkg::*;
	import core_pkg::*;
(
	input  wire              clock,
	input  wire              reset,
	input  wire              flush,
	input  wire  instr_t     fetched_instr,
	input  wire  pc_t        fetched_pc,
	input  wire              fetched_valid,
	input  wire              wb_valid,
	input  wire  reg_idx_t   wb_index,
	output logic             stall,
	output read_op_t         read_op,
	output logic             read_valid
);

	logic [NUM_REGS-1:0] board;
	logic [NUM_REGS-1:0] board_set;
	logic [NUM_REGS-1:0] board_clr;
	opcode_t             opcode;
	reg_idx_t            dst;
	reg_idx_t            src1;
	reg_idx_t            src2;
	logic                wr;
	logic                mark;
	logic                hazard;
	logic                issue;

	assign opcode = fetched_instr.opcode;
	assign dst    = fetched_instr.dst;
	assign src1   = fetched_instr.src1;
	assign src2   = fetched_instr.src2;

	assign wr   = op_writes_reg(opcode);
	// Register 0 is never pending
	assign mark = wr & (dst != '0);

	assign hazard = (op_reads_src1(opcode) & board[src1]) |
		(op_reads_src2(opcode) & board[src2]) |
		(mark & board[dst]);

	assign stall = fetched_valid & hazard;
	assign issue = fetched_valid & ~hazard & ~flush;

	assign board_set = (issue && mark) ? (NUM_REGS'(1) << dst) : '0;
	assign board_clr = wb_valid ? (NUM_REGS'(1) << wb_index) : '0;

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			board <= '0;
		end else begin
			board <= (board & ~board_clr) | board_set;
		end
	end

	//////////////////////////////
	// Issue register

	always_ff @(posedge clock) begin
		if (reset) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			read_op.opcode <= opcode;
			read_op.dst    <= dst;
			read_op.src1   <= src1;
			read_op.src2   <= src2;
			read_op.imm    <= fetched_instr.imm;
			read_op.pc     <= fetched_pc;
			read_op.wr     <= wr;
		end
	end

	// Write-back only retires a pending register
	a_clear_pending: assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> board[wb_index]);

endmodule

`default_nettype wire

//--- reg_file.sv
/*
	16 x 32-bit register file, two combinational reads and one write.
	Register 0 reads zero and ignores writes.
	A write is visible to reads from the cycle after the write edge.
*/
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import core_pkg::*;
(
	input  wire             clock,
	input  wire             reset,
	input  wire  reg_idx_t  read_idx1,
	input  wire  reg_idx_t  read_idx2,
	output data_t           read_data1,
	output data_t           read_data2,
	input  wire             write_en,
	input  wire  reg_idx_t  write_idx,
	input  wire  data_t     write_data
);

	data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_idx != '0) begin
			regs[write_idx] <= write_data;
		end
	end

	// Hard zero on register 0
	assign read_data1 = (read_idx1 == '0) ? '0 : regs[read_idx1];
	assign read_data2 = (read_idx2 == '0) ? '0 : regs[read_idx2];

endmodule

`default_nettype wire

//--- scalar_exec.sv
/*
	Execute and write-back stage.
	ALU result and branch decision are combinational, the write-back is registered.
	A taken BEQ, a JMP or a HALT flushes every younger instruction.
	term rises on HALT and falls when the next program reaches execute.
*/
`timescale 1ns/1ps
`default_nettype none

module scalar_exec
	import isa_pkg::*;
	import core_pkg::*;
(
	input  wire              clock,
	input  wire              reset,
	input  wire  exec_op_t   exec_op,
	input  wire              exec_valid,
	output logic             redirect,
	output pc_t              redirect_pc,
	output logic             flush,
	output logic             halt,
	output logic             term,
	output logic             wb_valid,
	output reg_idx_t         wb_index,
	output data_t            wb_data
);

	opcode_t opcode;
	data_t   a;
	data_t   b;
	data_t   imm_sx;
	data_t   result;
	logic    taken;
	logic    wb_en;

	assign opcode = exec_op.op.opcode;
	assign a      = exec_op.src1_data;
	assign b      = exec_op.src2_data;
	assign imm_sx = {{(DATA_W-16){exec_op.op.imm[15]}}, exec_op.op.imm};

	//////////////////////////////
	// ALU

	always_comb begin
		case (opcode)
			OP_ADD:  result = a + b;
			OP_SUB:  result = a - b;
			OP_AND:  result = a & b;
			OP_OR:   result = a | b;
			OP_XOR:  result = a ^ b;
			OP_SHL:  result = a << b[4:0];
			OP_SHR:  result = a >> b[4:0];
			OP_ADDI: result = a + imm_sx;
			OP_LUI:  result = {exec_op.op.imm, 16'h0000};
			default: result = '0;
		endcase
	end

	//////////////////////////////
	// Branch and halt

	assign taken = (opcode == OP_JMP) || (opcode == OP_BEQ && a == b);

	assign redirect = exec_valid & taken;
	// 16-bit add wraps the same as a sign-extended offset
	assign redirect_pc = (opcode == OP_JMP) ? exec_op.op.imm :
		exec_op.op.pc + exec_op.op.imm;
	assign halt  = exec_valid & (opcode == OP_HALT);
	assign flush = redirect | halt;

	assign wb_en = exec_valid & exec_op.op.wr & (exec_op.op.dst != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
			term     <= 1'b0;
		end else begin
			wb_valid <= wb_en;
			if (halt) begin
				term <= 1'b1;
			end else if (exec_valid) begin
				term <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wb_en) begin
			wb_index <= exec_op.op.dst;
			wb_data  <= result;
		end
	end

	// Read, issue and fetch slots are all emptied behind a flush
	a_flush_kills: assert property (@(posedge clock) disable iff (reset)
		exec_valid |-> !$past(flush) && !$past(flush, 2) && !$past(flush, 3));

endmodule

`default_nettype wire

//--- scalar_unit.sv
/*
	Scalar issue pipeline: fetch, issue, register read, execute/write-back.
	Load the program with the store handshake, then pulse start while idle.
	start is ignored while busy. term is held low while a program runs.
*/
`timescale 1ns/1ps
`default_nettype none

module scalar_unit
	import isa_pkg::*;
	import core_pkg::*;
#(
	parameter int IMEM_DEPTH = 64,
	localparam int AW = $clog2(IMEM_DEPTH)
) (
	input  wire            clock,
	input  wire            reset,
	input  wire            store_req,
	input  wire  [AW-1:0]  store_addr,
	input  wire  instr_t   store_instr,
	output logic           store_ack,
	input  wire            start,
	output logic           busy,
	output logic           term,
	output logic           wb_valid,
	output reg_idx_t       wb_index,
	output data_t          wb_data
);

	logic          start_ok;
	logic          fetch_valid;
	logic [AW-1:0] fetch_addr;
	instr_t        fetch_instr;
	instr_t        fetched_instr;
	pc_t           fetched_pc;
	logic          fetched_valid;
	logic          stall;
	read_op_t      read_op;
	logic          read_valid;
	data_t         read_data1;
	data_t         read_data2;
	exec_op_t      exec_op;
	logic          exec_valid;
	logic          redirect;
	pc_t           redirect_pc;
	logic          flush;
	logic          halt;
	logic          exec_term;

	assign start_ok = start & ~busy;
	assign term     = exec_term & ~busy;

	// Run flag
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (start_ok) begin
			busy <= 1'b1;
		end else if (halt) begin
			busy <= 1'b0;
		end
	end

	instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem (
		.clock(clock), .reset(reset),
		.store_req(store_req), .store_addr(store_addr), .store_instr(store_instr),
		.store_ack(store_ack),
		.fetch_valid(fetch_valid), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr),
		.busy(busy)
	);

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
		.clock(clock), .reset(reset), .start(start_ok), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt(halt),
		.fetch_instr(fetch_instr), .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
		.fetched_instr(fetched_instr), .fetched_pc(fetched_pc),
		.fetched_valid(fetched_valid)
	);

	hazard_issue u_issue (
		.clock(clock), .reset(reset), .flush(flush),
		.fetched_instr(fetched_instr), .fetched_pc(fetched_pc),
		.fetched_valid(fetched_valid),
		.wb_valid(wb_valid), .wb_index(wb_index),
		.stall(stall), .read_op(read_op), .read_valid(read_valid)
	);

	reg_file u_rf (
		.clock(clock), .reset(reset),
		.read_idx1(read_op.src1), .read_idx2(read_op.src2),
		.read_data1(read_data1), .read_data2(read_data2),
		.write_en(wb_valid), .write_idx(wb_index), .write_data(wb_data)
	);

	//////////////////////////////
	// Register read stage

	always_ff @(posedge clock) begin
		if (reset) begin
			exec_valid <= 1'b0;
		end else begin
			exec_valid <= read_valid & ~flush;
		end
	end

	always_ff @(posedge clock) begin
		exec_op.op        <= read_op;
		exec_op.src1_data <= read_data1;
		exec_op.src2_data <= read_data2;
	end

	scalar_exec u_exec (
		.clock(clock), .reset(reset),
		.exec_op(exec_op), .exec_valid(exec_valid),
		.redirect(redirect), .redirect_pc(redirect_pc), .flush(flush),
		.halt(halt), .term(exec_term),
		.wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

//--- tb_checks.svh
/*
	Compare tasks of the scalar pipeline testbench, one per result kind.
	Included inside the testbench module, which provides abort_run.
	All compares are exact, so X or Z on a DUT output counts as a mismatch.
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Write-back value
task automatic check_data(input string name, input data_t got, input data_t exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

// Write-back register index
task automatic check_index(input string name, input reg_idx_t got, input reg_idx_t exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

// Single-bit status such as term, busy or store_ack
task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

`endif

//--- tb_scalar_unit.sv
/*
	Testbench of the scalar issue pipeline.
	Stimulus and expected write-backs come from scalar_trace.txt in the project root.
	Each start record is followed by its write-back records and closed by a halt record.
	The run stops at the first mismatch. The cycle limit is 40 per record plus 100.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_scalar_unit
	import isa_pkg::*;
	import core_pkg::*;
;

	localparam int IMEM_DEPTH   = 64;
	localparam int AW           = $clog2(IMEM_DEPTH);
	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 4;
	localparam int TRACE_DEPTH  = 256;

	// Trace record kinds, top nibble of each 48-bit record
	localparam logic [3:0] REC_LOAD  = 4'h1;
	localparam logic [3:0] REC_START = 4'h2;
	localparam logic [3:0] REC_WB    = 4'h3;
	localparam logic [3:0] REC_HALT  = 4'h4;
	localparam logic [3:0] REC_END   = 4'hF;

	logic          clock;
	logic          reset;
	logic          store_req;
	logic [AW-1:0] store_addr;
	instr_t        store_instr;
	logic          store_ack;
	logic          start;
	logic          busy;
	logic          term;
	logic          wb_valid;
	reg_idx_t      wb_index;
	data_t         wb_data;

	logic [47:0] trace [TRACE_DEPTH];
	int          num_records;
	int          timeout_limit = 0;
	int          cycle_count = 0;
	reg_idx_t    exp_index [$];
	data_t       exp_data [$];

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	`include "tb_checks.svh"

	scalar_unit #(.IMEM_DEPTH(IMEM_DEPTH)) DUT (
		.clock(clock), .reset(reset),
		.store_req(store_req), .store_addr(store_addr), .store_instr(store_instr),
		.store_ack(store_ack),
		.start(start), .busy(busy), .term(term),
		.wb_valid(wb_valid), .wb_index(wb_index), .wb_data(wb_data)
	);

	always #CLK_HALF clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			abort_run();
		end
	end

	//////////////////////////////
	// Write-back monitor

	always @(negedge clock) begin
		if (!reset && wb_valid) begin
			if (exp_index.size() == 0) begin
				$display("Write-back to register %0d arrived when none was expected",
					wb_index);
				abort_run();
			end else begin
				check_index("wb_index", wb_index, exp_index.pop_front());
				check_data("wb_data", wb_data, exp_data.pop_front());
			end
		end
	end

	function automatic logic [3:0] record_kind(input int i);
		return trace[i][47:44];
	endfunction

	// Four-phase store, ack expected one edge after each req change
	task automatic store_word(input logic [AW-1:0] addr, input instr_t instr);
		int idle;
		idle = $urandom_range(3, 0);
		repeat (idle) @(posedge clock);
		@(posedge clock);
		store_addr  <= addr;
		store_instr <= instr;
		@(posedge clock);
		store_req <= 1'b1;
		@(negedge clock);
		check_flag("store_ack", store_ack, 1'b0);
		@(negedge clock);
		check_flag("store_ack", store_ack, 1'b1);
		@(posedge clock);
		store_req <= 1'b0;
		@(negedge clock);
		check_flag("store_ack", store_ack, 1'b1);
		@(negedge clock);
		check_flag("store_ack", store_ack, 1'b0);
	endtask

	// Start pulse, then wait until busy falls
	task automatic run_program();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		check_flag("busy", busy, 1'b1);
		check_flag("term", term, 1'b0);
		do @(negedge clock); while (busy);
		if (exp_index.size() != 0) begin
			$display("Program halted with %0d expected write-backs still missing",
				exp_index.size());
			abort_run();
		end
		check_flag("term", term, 1'b1);
	endtask

	initial begin
		int rec;
		clock       = 1'b0;
		reset       = 1'b1;
		store_req   = 1'b0;
		store_addr  = '0;
		store_instr = '0;
		start       = 1'b0;
		void'($urandom(32'h798));

		$readmemh("scalar_trace.txt", trace);
		num_records = 0;
		while (num_records < TRACE_DEPTH && record_kind(num_records) != REC_END) begin
			num_records++;
		end
		if (num_records == TRACE_DEPTH) begin
			$display("Trace file has no end record");
			abort_run();
		end
		timeout_limit = 40 * num_records + 100;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		for (rec = 0; rec < num_records; rec++) begin
			case (record_kind(rec))
				REC_LOAD: store_word(trace[rec][32 +: AW], instr_t'(trace[rec][31:0]));
				REC_START: begin
					rec++;
					while (rec < num_records && record_kind(rec) == REC_WB) begin
						exp_index.push_back(trace[rec][35:32]);
						exp_data.push_back(trace[rec][31:0]);
						rec++;
					end
					if (rec >= num_records || record_kind(rec) != REC_HALT) begin
						$display("Start record at entry %0d is not closed by a halt record",
							rec);
						abort_run();
					end
					run_program();
				end
				default: begin
					$display("Unknown record kind %h at trace entry %0d",
						record_kind(rec), rec);
					abort_run();
				end
			endcase
		end

		// Quiet tail, a late write-back is caught by the monitor
		repeat (10) @(negedge clock);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- scalar_trace.txt
// Columns: kind (1 hex digit), field (3 hex), data (8 hex); one 48-bit record per word
// Kinds: 1 load addr/instr, 2 start, 3 write-back index/data, 4 halt, F end of trace
// Program 1: ALU ops, ADDI, LUI, dependent chains, write to r0
100091001234 100181105678 // LUI r1,0x1234      ADDI r1,r1,0x5678
10028200FFFC 100313120000 // ADDI r2,r0,-4      ADD r3,r1,r2
100424130000 100555120000 // SUB r4,r1,r3       XOR r5,r1,r2
100686000FF0 100737160000 // ADDI r6,r0,0xff0   AND r7,r1,r6
100848740000 100969140000 // OR r8,r7,r4        SHL r9,r1,r4
100A7A540000 100B10110000 // SHR r10,r5,r4      ADD r0,r1,r1
100C8B000025 100D6C4B0000 // ADDI r11,r0,0x25   SHL r12,r4,r11
100EF0000000              // HALT
200000000000
300112340000 300112345678 3002FFFFFFFC 300312345674
300400000004 3005EDCBA984 300600000FF0 300700000670
300800000674 300923456780 300A0EDCBA98 300B00000025
300C00000080 400000000000
// Program 2: taken and untaken BEQ, JMP, backward branch
100081000003 100182000003 // ADDI r1,r0,3       ADDI r2,r0,3
1002A0120003 100383000BAD // BEQ r1,r2,+3       ADDI r3 (skipped)
100484000BAD 100585000011 // ADDI r4 (skipped)  ADDI r5,r0,0x11
1006A0150004 100786000022 // BEQ r1,r5,+4       ADDI r6,r0,0x22
1008B000000C 100987000BAD // JMP 12             ADDI r7 (skipped)
100A88000BAD 100BF0000000 // ADDI r8 (skipped)  HALT (skipped)
100C89000033 100DA0000003 // ADDI r9,r0,0x33    BEQ r0,r0,+3
100E8A000044 100FF0000000 // ADDI r10,r0,0x44   HALT
1010A099FFFE              // BEQ r9,r9,-2
200000000000
300100000003 300200000003 300500000011 300600000022
300900000033 300A00000044 400000000000
// Program 3: second restart, back-to-back dependences
100081000001 100111110000 // ADDI r1,r0,1       ADD r1,r1,r1
100211110000 100322010000 // ADD r1,r1,r1       SUB r2,r0,r1
100480200007 100553200000 // ADDI r0,r2,7       XOR r3,r2,r0
100674310000 1007F0000000 // SHR r4,r3,r1       HALT
200000000000
300100000001 300100000002 300100000004 3002FFFFFFFC
3003FFFFFFFC 30040FFFFFFF 400000000000
F00000000000

//--- vlog.f
+incdir+.
isa_pkg.sv
core_pkg.sv
instr_mem.sv
fetch_unit.sv
hazard_issue.sv
reg_file.sv
scalar_exec.sv
scalar_unit.sv
tb_scalar_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Build the scalar pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_scalar_unit -o tb_scalar_unit

sim_out=$(./obj_dir/tb_scalar_unit 2>&1) || true
echo "$sim_out"

if grep -qx "TEST PASS" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
